// ==== corr_top.f ====
logic/corr_pkg.sv
logic/corr_ctrl.sv
logic/operand_regs.sv
logic/mac_cell.sv
logic/systolic_grid.sv
logic/result_bank.sv
logic/corr_top.sv
dv/corr_checker.sv
dv/corr_tb.sv

// ==== Makefile ====
SIM        := verilator
TOP        := corr_tb
FILELIST   := corr_top.f
OBJ_DIR    := obj_dir
BUILD_FLAGS := --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS  := --lint-only --timing --assert --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/corr_tb.sv ====
`timescale 1ns/1ps

module corr_tb;

    localparam int TAPS       = corr_pkg::DEF_TAPS;
    localparam int DW         = corr_pkg::DEF_DATA_WIDTH;
    localparam int AW         = corr_pkg::ADDR_WIDTH;
    localparam int NSAMP      = 2 * TAPS - 1;
    // Exact width for a sum of TAPS signed products
    localparam int ACC_W      = 2 * DW + $clog2(TAPS + 1);
    localparam int SETTLE     = 3 * TAPS;
    localparam int WAIT_LIMIT = 100;
    localparam logic [DW-1:0] MOST_NEG = {1'b1, {(DW-1){1'b0}}};

    logic               clk;
    logic               rst_n;
    logic               req;
    corr_pkg::corr_op_e op;
    logic [AW-1:0]      addr;
    logic [DW-1:0]      wdata;
    logic               ack;
    logic [ACC_W-1:0]   rdata;

    // Model of operands and of the last captured results
    logic [DW-1:0]    tap_m  [TAPS];
    logic [DW-1:0]    samp_m [NSAMP];
    logic [ACC_W-1:0] res_m  [TAPS];
    logic [15:0]      lfsr;

    // Reads waiting for the compare process
    string            name_q [$];
    logic [ACC_W-1:0] exp_q  [$];
    logic [ACC_W-1:0] act_q  [$];

    int value_errors;
    int protocol_errors;
    int timeouts;

    corr_top #(
        .TAPS      (TAPS),
        .DATA_WIDTH(DW)
    ) corr_top_inst (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (req),
        .op   (op),
        .addr (addr),
        .wdata(wdata),
        .ack  (ack),
        .rdata(rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Stimulus data and reference model
    //////////////////////////////////////////////////

    // Galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [DW-1:0] rand_word();
        logic [DW-1:0] w;
        w = '0;
        for (int i = 0; i < DW; i++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[DW-2:0], lfsr[0]};
        end
        return w;
    endfunction

    // Lag d is the sum over i of tap i times sample d+i
    function automatic logic [ACC_W-1:0] ref_lag(input int d);
        longint acc;
        acc = 0;
        for (int i = 0; i < TAPS; i++) begin
            acc += longint'($signed(tap_m[i])) * longint'($signed(samp_m[d+i]));
        end
        return ACC_W'(acc);
    endfunction

    function automatic logic [ACC_W-1:0] expected_read(input int d);
        if (d < TAPS) begin
            return res_m[d];
        end else begin
            return '0;
        end
    endfunction

    //////////////////////////////////////////////////
    // Host side handshake
    //////////////////////////////////////////////////

    task automatic close_run();
        $display("Closing: %0d value errors, %0d protocol errors, %0d timeouts",
                 value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    // ack is sampled on falling edges, away from the DUT updates
    task automatic wait_for_ack(input logic level, output int cycles);
        cycles = 0;
        while (ack !== level && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (ack !== level) begin
            $display("Timeout: ack did not reach %0d within %0d cycles", level, WAIT_LIMIT);
            timeouts++;
            close_run();
        end
    endtask

    task automatic run_cmd(input corr_pkg::corr_op_e cmd, input logic [AW-1:0] a,
                           input logic [DW-1:0] d, input int hold,
                           output logic [ACC_W-1:0] rd);
        int cycles;
        int exp_lat;
        // Negedges up to the one after edge k, a run adds SETTLE+1 edges
        exp_lat = (cmd == corr_pkg::OP_RUN) ? SETTLE + 3 : 2;
        @(posedge clk);
        req   <= 1'b1;
        op    <= cmd;
        addr  <= a;
        wdata <= d;
        wait_for_ack(1'b1, cycles);
        rd = rdata;
        assert (cycles == exp_lat) else begin
            $display("Error ack_latency %s: expected %0d, actual %0d",
                     cmd.name(), exp_lat, cycles);
            protocol_errors++;
        end
        for (int h = 0; h < hold; h++) begin
            @(negedge clk);
            assert (ack === 1'b1) else begin
                $display("ack dropped while req was still held high");
                protocol_errors++;
            end
        end
        @(posedge clk);
        req <= 1'b0;
        wait_for_ack(1'b0, cycles);
        // Engine drops ack on the edge after it sees req low
        assert (cycles == 2) else begin
            $display("Error ack_release %s: expected 2, actual %0d", cmd.name(), cycles);
            protocol_errors++;
        end
    endtask

    task automatic write_tap(input int i, input logic [DW-1:0] v);
        logic [ACC_W-1:0] rd;
        run_cmd(corr_pkg::OP_LOAD_TAP, AW'(i), v, 0, rd);
        tap_m[i] = v;
    endtask

    task automatic write_sample(input int i, input logic [DW-1:0] v);
        logic [ACC_W-1:0] rd;
        run_cmd(corr_pkg::OP_LOAD_SAMPLE, AW'(i), v, 0, rd);
        samp_m[i] = v;
    endtask

    task automatic run_engine(input int hold);
        logic [ACC_W-1:0] rd;
        run_cmd(corr_pkg::OP_RUN, '0, '0, hold, rd);
        for (int d = 0; d < TAPS; d++) begin
            res_m[d] = ref_lag(d);
        end
    endtask

    task automatic check_read(input string name, input int d, input int hold);
        logic [ACC_W-1:0] rd;
        run_cmd(corr_pkg::OP_READ, AW'(d), '0, hold, rd);
        name_q.push_back($sformatf("%s[%0d]", name, d));
        exp_q.push_back(expected_read(d));
        act_q.push_back(rd);
    endtask

    task automatic check_all(input string name);
        for (int d = 0; d < TAPS; d++) begin
            check_read(name, d, 0);
        end
    endtask

    //////////////////////////////////////////////////
    // Compare process
    //////////////////////////////////////////////////

    initial begin
        string            nm;
        logic [ACC_W-1:0] e;
        logic [ACC_W-1:0] a;
        forever begin
            @(posedge clk);
            while (exp_q.size() > 0) begin
                nm = name_q.pop_front();
                e  = exp_q.pop_front();
                a  = act_q.pop_front();
                assert (a === e) else begin
                    $display("Error %s: expected %h, actual %h", nm, e, a);
                    value_errors++;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        int waited;
        rst_n           = 1'b0;
        req             = 1'b0;
        op              = corr_pkg::OP_LOAD_TAP;
        addr            = '0;
        wdata           = '0;
        lfsr            = 16'd39;
        value_errors    = 0;
        protocol_errors = 0;
        timeouts        = 0;
        for (int i = 0; i < TAPS; i++) begin
            tap_m[i] = '0;
            res_m[i] = '0;
        end
        for (int i = 0; i < NSAMP; i++) begin
            samp_m[i] = '0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (ack === 1'b0) else begin
            $display("ack is not low after reset");
            protocol_errors++;
        end
        // Nothing captured yet, every lag reads zero
        check_all("reset");

        // Random operands
        for (int i = 0; i < TAPS; i++) write_tap(i, rand_word());
        for (int i = 0; i < NSAMP; i++) write_sample(i, rand_word());
        run_engine(0);
        check_all("random");

        // New samples, taps kept
        write_sample(0, rand_word());
        write_sample(3, rand_word());
        write_sample(NSAMP - 1, rand_word());
        run_engine(0);
        check_all("resample");

        // Largest magnitude products
        for (int i = 0; i < TAPS; i++) write_tap(i, MOST_NEG);
        for (int i = 0; i < NSAMP; i++) write_sample(i, MOST_NEG);
        run_engine(0);
        check_all("most_negative");

        // Operand writes alone do not touch the result bank
        for (int i = 0; i < TAPS; i++) write_tap(i, rand_word());
        check_all("no_run");
        for (int d = TAPS; d < 2 ** AW; d++) begin
            check_read("out_of_range", d, 0);
        end

        // req held past ack
        check_read("hold_read", 1, 5);
        run_engine(3);
        check_all("hold_run");

        waited = 0;
        while (exp_q.size() > 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("Timeout: compare queue still holds %0d reads", exp_q.size());
            timeouts++;
        end
        close_run();
    end

endmodule

// ==== dv/corr_checker.sv ====
`timescale 1ns/1ps

module corr_checker (
    input logic clk,
    input logic rst_n,
    input logic req,
    input logic ack
);

    //////////////////////////////////////////////////
    // Four-phase handshake rules
    //////////////////////////////////////////////////

    // ack only comes up in answer to a pending req
    ack_rise_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(ack) |-> req
    ) else $error("ack rose while req was low");

    // Back-pressure, ack held for as long as req is held
    ack_held_with_req: assert property (
        @(posedge clk) disable iff (!rst_n) (ack && req) |=> ack
    ) else $error("ack dropped while req was still high");

    // ack falls only once req has been seen low
    ack_fall_after_req: assert property (
        @(posedge clk) disable iff (!rst_n) $fell(ack) |-> $past(!req)
    ) else $error("ack fell before req went low");

endmodule

bind corr_ctrl corr_checker checker_inst (
    .clk  (clk),
    .rst_n(rst_n),
    .req  (req),
    .ack  (ack)
);

// ==== logic/corr_top.sv ====
`timescale 1ns/1ps

module corr_top #(
    parameter int TAPS          = corr_pkg::DEF_TAPS,
    parameter int DATA_WIDTH    = corr_pkg::DEF_DATA_WIDTH,
    // Room for TAPS full products without overflow
    parameter int ACC_WIDTH     = 2 * DATA_WIDTH + $clog2(TAPS + 1),
    parameter int SETTLE_CYCLES = 3 * TAPS
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            req,
    input  corr_pkg::corr_op_e              op,
    input  logic [corr_pkg::ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0]           wdata,
    output logic                            ack,
    output logic [ACC_WIDTH-1:0]            rdata
);

    logic                  tap_we;
    logic                  sample_we;
    logic                  capture;
    logic [DATA_WIDTH-1:0] taps     [TAPS];
    logic [DATA_WIDTH-1:0] samples  [2*TAPS-1];
    logic [ACC_WIDTH-1:0]  lag_sums [TAPS];

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////

    corr_ctrl #(
        .SETTLE_CYCLES(SETTLE_CYCLES)
    ) u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .op       (op),
        .ack      (ack),
        .tap_we   (tap_we),
        .sample_we(sample_we),
        .capture  (capture)
    );

    //////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////

    operand_regs #(
        .TAPS      (TAPS),
        .DATA_WIDTH(DATA_WIDTH)
    ) u_operands (
        .clk      (clk),
        .rst_n    (rst_n),
        .tap_we   (tap_we),
        .sample_we(sample_we),
        .addr     (addr),
        .wdata    (wdata),
        .taps     (taps),
        .samples  (samples)
    );

    systolic_grid #(
        .TAPS      (TAPS),
        .DATA_WIDTH(DATA_WIDTH),
        .ACC_WIDTH (ACC_WIDTH)
    ) u_grid (
        .clk     (clk),
        .rst_n   (rst_n),
        .taps    (taps),
        .samples (samples),
        .lag_sums(lag_sums)
    );

    result_bank #(
        .TAPS     (TAPS),
        .ACC_WIDTH(ACC_WIDTH)
    ) u_results (
        .clk     (clk),
        .rst_n   (rst_n),
        .capture (capture),
        .lag_sums(lag_sums),
        .addr    (addr),
        .rdata   (rdata)
    );

endmodule

// ==== logic/result_bank.sv ====
`timescale 1ns/1ps

module result_bank #(
    parameter int TAPS      = 4,
    parameter int ACC_WIDTH = 35
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            capture,
    input  logic [ACC_WIDTH-1:0]            lag_sums [TAPS],
    input  logic [corr_pkg::ADDR_WIDTH-1:0] addr,
    output logic [ACC_WIDTH-1:0]            rdata
);

    // Lags latched at the end of the last run
    logic [ACC_WIDTH-1:0] held [TAPS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < TAPS; i++) begin
                held[i] <= '0;
            end
        end else if (capture) begin
            held <= lag_sums;
        end
    end

    // Indexed read, zero for lags past TAPS-1
    always_comb begin
        rdata = '0;
        for (int i = 0; i < TAPS; i++) begin
            if (int'(addr) == i) rdata = held[i];
        end
    end

endmodule

// ==== logic/systolic_grid.sv ====
`timescale 1ns/1ps

module systolic_grid #(
    parameter int TAPS       = 4,
    parameter int DATA_WIDTH = 16,
    parameter int ACC_WIDTH  = 35
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [DATA_WIDTH-1:0] taps [TAPS],
    input  logic [DATA_WIDTH-1:0] samples [2*TAPS-1],
    output logic [ACC_WIDTH-1:0]  lag_sums [TAPS]
);

    localparam int COLS = 2 * TAPS - 1;

    // Registered outputs of every position, indexed [row][col]
    wire [DATA_WIDTH-1:0] a_q  [TAPS][COLS];
    wire [DATA_WIDTH-1:0] b_q  [TAPS][COLS];
    wire [ACC_WIDTH-1:0]  psum [TAPS][COLS];

    //////////////////////////////////////////////////
    // Cell array
    //////////////////////////////////////////////////

    for (genvar r = 0; r < TAPS; r++) begin : g_row
        for (genvar c = 0; c < COLS; c++) begin : g_col
            logic [DATA_WIDTH-1:0] a_in;
            logic [DATA_WIDTH-1:0] b_in;

            // Row r carries tap r, column c carries sample c
            assign a_in = (c == 0) ? taps[r] : a_q[r][(c == 0) ? 0 : c-1];
            assign b_in = (r == 0) ? samples[c] : b_q[(r == 0) ? 0 : r-1][c];

            if (c >= r) begin : g_mac
                logic [ACC_WIDTH-1:0] c_in;
                // Top row starts each diagonal from zero
                assign c_in = (r == 0) ? '0 : psum[(r == 0) ? 0 : r-1][(c == 0) ? 0 : c-1];

                mac_cell #(
                    .DATA_WIDTH(DATA_WIDTH),
                    .ACC_WIDTH (ACC_WIDTH)
                ) u_cell (
                    .clk  (clk),
                    .rst_n(rst_n),
                    .a_in (a_in),
                    .b_in (b_in),
                    .c_in (c_in),
                    .a_out(a_q[r][c]),
                    .b_out(b_q[r][c]),
                    .c_out(psum[r][c])
                );
            end else begin : g_fwd
                logic [DATA_WIDTH-1:0] a_fwd;
                logic [DATA_WIDTH-1:0] b_fwd;

                // Below the diagonal operands only pass through
                always_ff @(posedge clk or negedge rst_n) begin
                    if (!rst_n) begin
                        a_fwd <= '0;
                        b_fwd <= '0;
                    end else begin
                        a_fwd <= a_in;
                        b_fwd <= b_in;
                    end
                end

                assign a_q[r][c]  = a_fwd;
                assign b_q[r][c]  = b_fwd;
                // No partial sum here
                assign psum[r][c] = '0;
            end
        end
    end

    // Bottom row from column TAPS-1 onward holds lags 0 to TAPS-1
    for (genvar d = 0; d < TAPS; d++) begin : g_lag
        assign lag_sums[d] = psum[TAPS-1][TAPS-1+d];
    end

endmodule

// ==== logic/mac_cell.sv ====
`timescale 1ns/1ps

module mac_cell #(
    parameter int DATA_WIDTH = 16,
    parameter int ACC_WIDTH  = 35
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [DATA_WIDTH-1:0] a_in,
    input  logic [DATA_WIDTH-1:0] b_in,
    input  logic [ACC_WIDTH-1:0]  c_in,
    output logic [DATA_WIDTH-1:0] a_out,
    output logic [DATA_WIDTH-1:0] b_out,
    output logic [ACC_WIDTH-1:0]  c_out
);

    // Full precision signed product
    logic signed [2*DATA_WIDTH-1:0] prod;

    assign prod = $signed(a_in) * $signed(b_in);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_out <= '0;
            b_out <= '0;
            c_out <= '0;
        end else begin
            // Tap moves right, sample moves down
            a_out <= a_in;
            b_out <= b_in;
            // Sign extend product into the accumulator width
            c_out <= c_in + {{(ACC_WIDTH-2*DATA_WIDTH){prod[2*DATA_WIDTH-1]}}, prod};
        end
    end

endmodule

// ==== logic/operand_regs.sv ====
`timescale 1ns/1ps

module operand_regs #(
    parameter int TAPS       = 4,
    parameter int DATA_WIDTH = 16
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            tap_we,
    input  logic                            sample_we,
    input  logic [corr_pkg::ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0]           wdata,
    output logic [DATA_WIDTH-1:0]           taps [TAPS],
    output logic [DATA_WIDTH-1:0]           samples [2*TAPS-1]
);

    localparam int NSAMP = 2 * TAPS - 1;

    // Tap file, feeds the left edge of the grid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < TAPS; i++) begin
                taps[i] <= '0;
            end
        end else if (tap_we) begin
            // Out of range addr matches no entry
            for (int i = 0; i < TAPS; i++) begin
                if (int'(addr) == i) taps[i] <= wdata;
            end
        end
    end

    // Sample file, feeds the top edge of the grid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NSAMP; i++) begin
                samples[i] <= '0;
            end
        end else if (sample_we) begin
            for (int i = 0; i < NSAMP; i++) begin
                if (int'(addr) == i) samples[i] <= wdata;
            end
        end
    end

endmodule

// ==== logic/corr_ctrl.sv ====
`timescale 1ns/1ps

module corr_ctrl #(
    parameter int SETTLE_CYCLES = 12
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req,
    input  corr_pkg::corr_op_e op,
    output logic               ack,
    output logic               tap_we,
    output logic               sample_we,
    output logic               capture
);

    localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

    corr_pkg::ctrl_state_e state;
    // Counts down the grid settle time during a run
    logic [CNT_W-1:0]      settle_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= corr_pkg::ST_IDLE;
            ack        <= 1'b0;
            tap_we     <= 1'b0;
            sample_we  <= 1'b0;
            capture    <= 1'b0;
            settle_cnt <= '0;
        end else begin
            // Strobes are single-cycle pulses
            tap_we    <= 1'b0;
            sample_we <= 1'b0;
            capture   <= 1'b0;
            case (state)
                corr_pkg::ST_IDLE: begin
                    if (req) begin
                        case (op)
                            corr_pkg::OP_LOAD_TAP: begin
                                tap_we <= 1'b1;
                                ack    <= 1'b1;
                                state  <= corr_pkg::ST_ACK;
                            end
                            corr_pkg::OP_LOAD_SAMPLE: begin
                                sample_we <= 1'b1;
                                ack       <= 1'b1;
                                state     <= corr_pkg::ST_ACK;
                            end
                            corr_pkg::OP_RUN: begin
                                settle_cnt <= CNT_W'(SETTLE_CYCLES - 1);
                                state      <= corr_pkg::ST_SETTLE;
                            end
                            default: begin
                                // Read data comes straight from the result bank
                                ack   <= 1'b1;
                                state <= corr_pkg::ST_ACK;
                            end
                        endcase
                    end
                end
                corr_pkg::ST_SETTLE: begin
                    if (capture) begin
                        // Results are latched on this edge, so ack can go up
                        ack   <= 1'b1;
                        state <= corr_pkg::ST_ACK;
                    end else if (settle_cnt == '0) begin
                        capture <= 1'b1;
                    end else begin
                        settle_cnt <= settle_cnt - 1'b1;
                    end
                end
                corr_pkg::ST_ACK: begin
                    // Hold ack until the host lets go of req
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= corr_pkg::ST_IDLE;
                    end
                end
                default: begin
                    ack   <= 1'b0;
                    state <= corr_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== logic/corr_pkg.sv ====
package corr_pkg;

    //////////////////////////////////////////////////
    // Host command set
    //////////////////////////////////////////////////

    // Opcode carried with every req
    typedef enum logic [1:0] {
        OP_LOAD_TAP    = 2'd0,
        OP_LOAD_SAMPLE = 2'd1,
        OP_RUN         = 2'd2,
        OP_READ        = 2'd3
    } corr_op_e;

    // Sequencer states
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_SETTLE = 2'd1,
        ST_ACK    = 2'd2
    } ctrl_state_e;

    //////////////////////////////////////////////////
    // Default sizes
    //////////////////////////////////////////////////

    localparam int DEF_TAPS       = 4;
    localparam int DEF_DATA_WIDTH = 16;
    // Covers the 2*TAPS-1 sample entries for TAPS up to 4
    localparam int ADDR_WIDTH     = 3;

endpackage
